/* Bender.yml */
package:
  name: z3_slave

sources:
  - include_dirs:
      - source
    files:
      - source/z3_pkg.sv
      - source/z3_cfg_if.sv
      - source/z3_addr_decode.sv
      - source/z3_autoconfig.sv
      - source/z3_cycle_fsm.sv
      - source/z3_slave_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/z3_slave_checker.sv
      - test/z3_slave_tb.sv

/* list.f */
+incdir+source
source/z3_pkg.sv
source/z3_cfg_if.sv
source/z3_addr_decode.sv
source/z3_autoconfig.sv
source/z3_cycle_fsm.sv
source/z3_slave_top.sv
test/z3_slave_checker.sv
test/z3_slave_tb.sv

/* source/z3_addr_decode.sv */
// zorro iii address latch, card and config space decode, slave select
`timescale 1ns/1ps
`default_nettype none

`include "z3_consts.svh"

module z3_addr_decode import z3_pkg::*; (
	input  wire          clk,
	input  wire          nIORST,
	input  wire          n_fcs_i,
	input  wire [31:8]   ad_i,
	input  wire [7:2]    a_i,
	input  wire [1:0]    fc_i,
	input  wire          n_cfgin_i,
	input  wire base_t   base_i,
	input  wire          configured_i,
	input  wire          shutup_i,
	output zaddr_t       addr_o,
	output logic         card_sel_o,
	output logic         cfg_sel_o,
	output logic         n_slave_o,
	output logic         match_o
);

	logic card_hit;
	logic cfg_hit;
	logic fc_ok;
	logic n_fcs_r;

	// ---------------------------------------------------------------------
	// address phase, AD goes away right after /FCS falls
	// ---------------------------------------------------------------------
	assign card_hit = (ad_i[31 -: `Z3_MATCH_BITS] == base_i[15 -: `Z3_MATCH_BITS])
		& configured_i;
	assign cfg_hit  = (ad_i[31:16] == `Z3_CFG_SPACE) & ~configured_i & ~shutup_i;

	// low bits are held for the whole cycle, latched anyway
	always_ff @(negedge n_fcs_i) begin
		addr_o <= {ad_i, a_i, 2'b00};
	end

	always_ff @(negedge n_fcs_i or negedge nIORST) begin
		if (!nIORST) begin
			card_sel_o <= 1'b0;
			cfg_sel_o  <= 1'b0;
		end else begin
			card_sel_o <= card_hit;
			cfg_sel_o  <= cfg_hit;
		end
	end

	// user or supervisor data/program space only
	assign fc_ok = fc_i[0] ^ fc_i[1];

	// must be fast, so no clk in this path
	assign n_slave_o = ~(~n_fcs_i & (card_sel_o | cfg_sel_o) & fc_ok & ~n_cfgin_i);

	// /FCS sync stage, then the match itself
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			n_fcs_r <= 1'b1;
			match_o <= 1'b0;
		end else begin
			n_fcs_r <= n_fcs_i;
			match_o <= ~n_slave_o & ~n_fcs_r;
		end
	end

endmodule

`default_nettype wire

/* source/z3_autoconfig.sv */
// zorro iii autoconfig rom, base address and shut-up registers, config chain out
`timescale 1ns/1ps
`default_nettype none

`include "z3_consts.svh"

module z3_autoconfig import z3_pkg::*; (
	input  wire    clk,
	input  wire    nIORST,
	z3_cfg_if.regs cfg,
	output base_t  base_o,
	output logic   configured_o,
	output logic   shutup_o,
	output logic   n_cfgout_o
);

	logic [7:0] rom_byte;
	nibble_t    rom_nib;
	logic       base_wr;
	logic       shutup_wr;

	// ---------------------------------------------------------------------
	// rom
	// ---------------------------------------------------------------------
	// index bits 5:0 pick the register, bit 6 the nibble
	always_comb begin
		unique case (cfg.reg_idx[5:0])
			6'h00: rom_byte = `Z3_ROM_TYPE;
			6'h01: rom_byte = `Z3_ROM_PRODUCT;
			6'h02: rom_byte = `Z3_ROM_FLAGS;
			6'h04: rom_byte = `Z3_ROM_MFR_HI;
			6'h05: rom_byte = `Z3_ROM_MFR_LO;
			default: rom_byte = 8'h00;
		endcase
	end

	always_comb begin
		rom_nib = cfg.reg_idx[6] ? rom_byte[3:0] : rom_byte[7:4];
		// only er_Type reads true, the rest is stored inverted
		if (cfg.reg_idx[5:0] != 6'h00) begin
			rom_nib = ~rom_nib;
		end
	end

	// bus floats high when not selected
	assign cfg.rdata = cfg.cfg_sel ? rom_nib : 4'hF;

	// ---------------------------------------------------------------------
	// write registers
	// ---------------------------------------------------------------------
	assign base_wr   = cfg.wr_stb & (cfg.reg_idx == `Z3_REG_BASE);
	assign shutup_wr = cfg.wr_stb & (cfg.reg_idx == `Z3_REG_SHUTUP);

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			base_o       <= '0;
			configured_o <= 1'b0;
		end else if (base_wr) begin
			// card moves out of FF00 into its assigned slot
			base_o       <= cfg.wdata;
			configured_o <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			shutup_o <= 1'b0;
		end else if (shutup_wr) begin
			shutup_o <= 1'b1;
		end
	end

	// pass the chain on once we are out of the way
	assign n_cfgout_o = ~(configured_o | shutup_o);

endmodule

`default_nettype wire

/* source/z3_cfg_if.sv */
// cfg register link between the slave cycle FSM and the autoconfig block
`timescale 1ns/1ps
`default_nettype none

interface z3_cfg_if import z3_pkg::*; ();

	// cycle is in config space
	logic     cfg_sel;
	// register index from the latched address
	reg_idx_t reg_idx;
	// one clk wide write strobe
	logic     wr_stb;
	// write data, bus bits 15:0
	base_t    wdata;
	// rom nibble for reg_idx
	nibble_t  rdata;

	modport fsm (
		output cfg_sel, reg_idx, wr_stb, wdata,
		input  rdata
	);

	modport regs (
		input  cfg_sel, reg_idx, wr_stb, wdata,
		output rdata
	);

endinterface

`default_nettype wire

/* source/z3_consts.svh */
// zorro iii slave constants: config space, register offsets, rom bytes, ack timeout
`ifndef Z3_CONSTS_SVH
`define Z3_CONSTS_SVH

// address bits 31:16 of the autoconfig window
`define Z3_CFG_SPACE		16'hFF00

// number of base bits compared against the bus address, from bit 31 down
`define Z3_MATCH_BITS		6

// register indices, i.e. byte offset divided by four
`define Z3_REG_BASE			7'h11
`define Z3_REG_SHUTUP		7'h13

// rom bytes, each read back as two nibbles
`define Z3_ROM_TYPE			8'hA1
`define Z3_ROM_PRODUCT		8'h10
`define Z3_ROM_FLAGS		8'h30
`define Z3_ROM_MFR_HI		8'h07
`define Z3_ROM_MFR_LO		8'hDB

// clk cycles in DTACK before the slave lets go
`define Z3_DTACK_TIMEOUT	48

`endif

/* source/z3_cycle_fsm.sv */
// zorro iii slave cycle FSM with memory request, read data register and dtack timeout
`timescale 1ns/1ps
`default_nettype none

`include "z3_consts.svh"

module z3_cycle_fsm import z3_pkg::*; (
	input  wire           clk,
	input  wire           nIORST,
	input  wire           n_fcs_i,
	input  wire           doe_i,
	input  wire           read_i,
	input  wire [3:0]     n_ds_i,
	input  wire           match_i,
	input  wire           card_sel_i,
	input  wire           cfg_sel_i,
	input  wire zaddr_t   addr_i,
	input  wire zdata_t   wdata_i,
	z3_cfg_if.fsm         cfg,
	output zdata_t        rdata_o,
	output logic          n_dtack_o,
	output logic          mem_stb_o,
	output logic          mem_we_o,
	output mem_addr_t     mem_addr_o,
	output zdata_t        mem_wdata_o,
	output byte_en_t      mem_be_o,
	input  wire zdata_t   mem_rdata_i,
	input  wire           mem_ack_i
);

	cycle_state_t state;
	cycle_state_t next_state;
	logic         doe_r;
	logic [3:0]   n_ds_r1;
	logic [3:0]   n_ds_r2;
	logic         ack_r;
	tmo_cnt_t     tmo_cnt;
	zdata_t       wdata_q;
	byte_en_t     be_q;
	logic         ds_seen;
	logic         stb_set;

	// ---------------------------------------------------------------------
	// synchronizers and registered memory ack
	// ---------------------------------------------------------------------
	// ack stays set until the cycle ends, a fast memory may answer in MATCH
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			doe_r   <= 1'b0;
			n_ds_r1 <= 4'hF;
			n_ds_r2 <= 4'hF;
			ack_r   <= 1'b0;
		end else begin
			doe_r   <= doe_i;
			n_ds_r1 <= n_ds_i;
			n_ds_r2 <= n_ds_r1;
			if (state == IDLE)
				ack_r <= 1'b0;
			else if (mem_ack_i)
				ack_r <= 1'b1;
		end
	end

	// any lane strobed
	assign ds_seen = (n_ds_r2 != 4'hF);

	// ---------------------------------------------------------------------
	// state machine
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		unique case (state)
			IDLE:       if (match_i) next_state = MATCH;
			MATCH:      if (doe_r) next_state = DATA;
			DATA: begin
				if (read_i) begin
					if (cfg_sel_i | ack_r)
						next_state = ACK_DELAY0;
				end else if (ds_seen) begin
					next_state = WRITE_STB;
				end
			end
			WRITE_STB:  next_state = WRITE_WAIT;
			// config writes finish in the strobe cycle
			WRITE_WAIT: if (cfg_sel_i | ack_r) next_state = DTACK;
			ACK_DELAY0: next_state = ACK_DELAY1;
			ACK_DELAY1: next_state = DTACK;
			DTACK: begin
				if (tmo_cnt == tmo_cnt_t'(`Z3_DTACK_TIMEOUT - 1))
					next_state = DTACK_ERR;
			end
			DTACK_ERR:  next_state = DTACK_ERR;
			default:    next_state = IDLE;
		endcase
		// master ends the cycle whenever it likes
		if (n_fcs_i)
			next_state = IDLE;
	end

	// master may hang on past our ack, count and let go
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			tmo_cnt <= '0;
		else if (state == DTACK)
			tmo_cnt <= tmo_cnt + 1'b1;
		else
			tmo_cnt <= '0;
	end

	assign n_dtack_o = ~((state == DTACK) & ~n_fcs_i);

	// ---------------------------------------------------------------------
	// memory request
	// ---------------------------------------------------------------------
	// reads start early, on entry to MATCH; writes wait for the data
	assign stb_set = card_sel_i &
		(((state == IDLE) & (next_state == MATCH) & read_i) |
		 ((state == DATA) & (next_state == WRITE_STB)));

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			mem_stb_o <= 1'b0;
		else
			mem_stb_o <= stb_set;
	end

	assign mem_we_o    = ~read_i;
	assign mem_addr_o  = addr_i[25:2];
	assign mem_wdata_o = wdata_q;
	// cachable reads get the full longword
	assign mem_be_o    = read_i ? 4'hF : be_q;

	// ---------------------------------------------------------------------
	// data registers
	// ---------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if ((state == DATA) & ~read_i & ds_seen) begin
			wdata_q <= wdata_i;
			be_q    <= ~n_ds_r2;
		end
	end

	// config nibble sits on D31:28, ones below
	always_ff @(posedge clk) begin
		if ((state == DATA) & read_i & cfg_sel_i)
			rdata_o <= {cfg.rdata, 28'hFFF_FFFF};
		else if (mem_ack_i & read_i)
			rdata_o <= mem_rdata_i;
	end

	// config register side
	assign cfg.cfg_sel = cfg_sel_i;
	assign cfg.reg_idx = addr_i[8:2];
	assign cfg.wdata   = wdata_q[15:0];
	assign cfg.wr_stb  = (state == WRITE_STB) & cfg_sel_i;

endmodule

`default_nettype wire

/* source/z3_pkg.sv */
// zorro iii slave types shared by the bus decode, cycle FSM and autoconfig blocks
`default_nettype none

package z3_pkg;

	typedef logic [31:0] zaddr_t;
	typedef logic [31:0] zdata_t;
	// bit 3 covers data 31:24
	typedef logic [3:0]  byte_en_t;
	// address bits 8:2, bit 6 picks the low nibble
	typedef logic [6:0]  reg_idx_t;
	typedef logic [3:0]  nibble_t;
	// card base, address bits 31:16
	typedef logic [15:0] base_t;
	// longword address into local memory
	typedef logic [23:0] mem_addr_t;
	typedef logic [7:0]  tmo_cnt_t;

	typedef enum logic [3:0] {
		IDLE, MATCH, DATA, WRITE_STB, WRITE_WAIT,
		ACK_DELAY0, ACK_DELAY1, DTACK, DTACK_ERR
	} cycle_state_t;

endpackage

`default_nettype wire

/* source/z3_slave_top.sv */
// zorro iii slave top, data lane mapping, read drivers and block instances
`timescale 1ns/1ps
`default_nettype none

module z3_slave_top import z3_pkg::*; (
	input  wire            clk,
	input  wire            nIORST,
	input  wire            n_fcs_i,
	input  wire            doe_i,
	input  wire            read_i,
	input  wire [1:0]      fc_i,
	input  wire [7:2]      a_i,
	input  wire [3:0]      n_ds_i,
	input  wire            n_cfgin_i,
	input  wire            n_berr_i,
	inout  wire [31:8]     ad_io,
	inout  wire [7:0]      sd_io,
	output logic           n_slave_o,
	output logic           n_dtack_o,
	output logic           n_cfgout_o,
	output logic           mem_stb_o,
	output logic           mem_we_o,
	output mem_addr_t      mem_addr_o,
	output zdata_t         mem_wdata_o,
	output byte_en_t       mem_be_o,
	input  wire zdata_t    mem_rdata_i,
	input  wire            mem_ack_i
);

	zaddr_t addr;
	zdata_t bus_wdata;
	zdata_t rdata;
	base_t  base;
	logic   card_sel;
	logic   cfg_sel;
	logic   match;
	logic   configured;
	logic   shutup;
	logic   dboe;

	z3_cfg_if u_cfg_if ();

	// ---------------------------------------------------------------------
	// lanes: D31:24 on AD31:24, D23:16 on SD, D15:0 on AD23:8
	// ---------------------------------------------------------------------
	assign bus_wdata = {ad_io[31:24], sd_io, ad_io[23:8]};

	// release on /BERR, the master may retry
	assign dboe = ~n_slave_o & doe_i & read_i & n_berr_i;

	assign ad_io[31:24] = dboe ? rdata[31:24] : 8'hzz;
	assign sd_io        = dboe ? rdata[23:16] : 8'hzz;
	assign ad_io[23:8]  = dboe ? rdata[15:0]  : 16'hzzzz;

	z3_addr_decode u_addr_decode (
		.clk          (clk),
		.nIORST       (nIORST),
		.n_fcs_i      (n_fcs_i),
		.ad_i         (ad_io),
		.a_i          (a_i),
		.fc_i         (fc_i),
		.n_cfgin_i    (n_cfgin_i),
		.base_i       (base),
		.configured_i (configured),
		.shutup_i     (shutup),
		.addr_o       (addr),
		.card_sel_o   (card_sel),
		.cfg_sel_o    (cfg_sel),
		.n_slave_o    (n_slave_o),
		.match_o      (match)
	);

	z3_cycle_fsm u_cycle_fsm (
		.clk         (clk),
		.nIORST      (nIORST),
		.n_fcs_i     (n_fcs_i),
		.doe_i       (doe_i),
		.read_i      (read_i),
		.n_ds_i      (n_ds_i),
		.match_i     (match),
		.card_sel_i  (card_sel),
		.cfg_sel_i   (cfg_sel),
		.addr_i      (addr),
		.wdata_i     (bus_wdata),
		.cfg         (u_cfg_if.fsm),
		.rdata_o     (rdata),
		.n_dtack_o   (n_dtack_o),
		.mem_stb_o   (mem_stb_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_be_o    (mem_be_o),
		.mem_rdata_i (mem_rdata_i),
		.mem_ack_i   (mem_ack_i)
	);

	z3_autoconfig u_autoconfig (
		.clk          (clk),
		.nIORST       (nIORST),
		.cfg          (u_cfg_if.regs),
		.base_o       (base),
		.configured_o (configured),
		.shutup_o     (shutup),
		.n_cfgout_o   (n_cfgout_o)
	);

endmodule

`default_nettype wire

/* test/z3_patterns.txt */
# name kind address data byte_en expected, all values hex
# cfgrd gives the rom nibble, memwr the word seen at the memory port
cfg_type_hi    cfgrd  FF000000  00000000  0  A
cfg_type_lo    cfgrd  FF000100  00000000  0  1
cfg_prod_hi    cfgrd  FF000004  00000000  0  E
cfg_flags_hi   cfgrd  FF000008  00000000  0  C
cfg_mfr_hi_lo  cfgrd  FF000110  00000000  0  8
cfg_mfr_lo_hi  cfgrd  FF000014  00000000  0  2
cfg_base_wr    cfgwr  FF000044  00004000  3  0
cfg_gone       cfgrd  FF000000  00000000  0  A
mem_wr_a       memwr  40000010  11223344  F  11223344
mem_wr_b       memwr  40000014  A5A55A5A  F  A5A55A5A
mem_wr_part    memwr  40000010  CCDDEEFF  5  CCDDEEFF
mem_rd_a       memrd  40000010  00000000  0  11DD33FF
mem_rd_b       memrd  40000014  00000000  0  A5A55A5A
mem_tmo        tmo    40000014  00000000  0  A5A55A5A

/* test/z3_slave_checker.sv */
// zorro iii slave bus rules: dtack idle, single memory strobe, config chain in reset
`timescale 1ns/1ps
`default_nettype none

module z3_slave_checker (
	input wire clk,
	input wire nIORST,
	input wire n_fcs_i,
	input wire n_dtack_i,
	input wire mem_stb_i,
	input wire n_cfgout_i
);

	// read back by the testbench at the end of the run
	int assert_fails = 0;

	// no acknowledge outside a bus cycle
	a_dtack_idle: assert property (@(posedge clk) disable iff (!nIORST)
		n_fcs_i |-> n_dtack_i)
	else begin
		assert_fails++;
		$error("n_dtack_o low while n_fcs_i is high");
	end

	// memory request is a single clk pulse
	a_stb_pulse: assert property (@(posedge clk) disable iff (!nIORST)
		mem_stb_i |=> !mem_stb_i)
	else begin
		assert_fails++;
		$error("mem_stb_o high for two cycles in a row");
	end

	a_cfgout_reset: assert property (@(posedge clk) !nIORST |-> n_cfgout_i)
	else begin
		assert_fails++;
		$error("n_cfgout_o low during reset");
	end

endmodule

bind z3_slave_top z3_slave_checker u_checker (
	.clk        (clk),
	.nIORST     (nIORST),
	.n_fcs_i    (n_fcs_i),
	.n_dtack_i  (n_dtack_o),
	.mem_stb_i  (mem_stb_o),
	.n_cfgout_i (n_cfgout_o)
);

`default_nettype wire

/* test/z3_slave_tb.sv */
// zorro iii slave testbench: bus master, memory model, pattern file and scoring
`timescale 1ns/1ps
`include "z3_consts.svh"
`default_nettype none

module z3_slave_tb import z3_pkg::*; ();

	localparam int MAX_TESTS = 32;

	logic       clk;
	logic       nIORST;
	logic       n_fcs_i;
	logic       doe_i;
	logic       read_i;
	logic [1:0] fc_i;
	logic [7:2] a_i;
	logic [3:0] n_ds_i;
	logic       n_cfgin_i;
	logic       n_berr_i;
	wire [31:8] ad_io;
	wire [7:0]  sd_io;
	logic       n_slave_o;
	logic       n_dtack_o;
	logic       n_cfgout_o;
	logic       mem_stb_o;
	logic       mem_we_o;
	mem_addr_t  mem_addr_o;
	zdata_t     mem_wdata_o;
	byte_en_t   mem_be_o;
	zdata_t     mem_rdata_i;
	logic       mem_ack_i;

	// master side of the shared AD/SD lines
	logic        ad_oe;
	logic [31:8] ad_drv;
	logic [7:0]  sd_drv;

	// memory model state and last request seen
	zdata_t      mem [0:255];
	logic [31:0] lfsr;
	int          stb_count;
	int          ack_count;
	logic        req_we;
	mem_addr_t   req_addr;
	zdata_t      req_wdata;
	byte_en_t    req_be;

	// pattern table
	reg [8*24-1:0] pat_name [0:MAX_TESTS-1];
	reg [8*8-1:0]  pat_kind [0:MAX_TESTS-1];
	zaddr_t        pat_addr [0:MAX_TESTS-1];
	zdata_t        pat_data [0:MAX_TESTS-1];
	byte_en_t      pat_be   [0:MAX_TESTS-1];
	zdata_t        pat_exp  [0:MAX_TESTS-1];

	int   n_tests;
	int   cycles;
	int   cycle_limit;
	int   test_errors;
	int   passed;
	int   failed;
	logic card_configured;

	assign ad_io = ad_oe ? ad_drv : 'z;
	assign sd_io = ad_oe ? sd_drv : 'z;

	z3_slave_top u_z3_slave_top (
		.clk         (clk),
		.nIORST      (nIORST),
		.n_fcs_i     (n_fcs_i),
		.doe_i       (doe_i),
		.read_i      (read_i),
		.fc_i        (fc_i),
		.a_i         (a_i),
		.n_ds_i      (n_ds_i),
		.n_cfgin_i   (n_cfgin_i),
		.n_berr_i    (n_berr_i),
		.ad_io       (ad_io),
		.sd_io       (sd_io),
		.n_slave_o   (n_slave_o),
		.n_dtack_o   (n_dtack_o),
		.n_cfgout_o  (n_cfgout_o),
		.mem_stb_o   (mem_stb_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_be_o    (mem_be_o),
		.mem_rdata_i (mem_rdata_i),
		.mem_ack_i   (mem_ack_i)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// ----------------------------------------------------------------------
	// run limit
	// ----------------------------------------------------------------------
	initial cycles = 0;
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: run reached the cycle limit of %0d", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// 32 bit fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// ----------------------------------------------------------------------
	// memory model, ack 1 to 8 cycles after the request
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		int delay;
		int k;
		if (mem_stb_o === 1'b1) begin
			stb_count++;
			req_we    = mem_we_o;
			req_addr  = mem_addr_o;
			req_wdata = mem_wdata_o;
			req_be    = mem_be_o;
			if (mem_we_o) begin
				for (k = 0; k < 4; k++) begin
					if (mem_be_o[k])
						mem[mem_addr_o[7:0]][8*k +: 8] = mem_wdata_o[8*k +: 8];
				end
			end
			// three lfsr bits, one step each
			delay = 0;
			for (k = 0; k < 3; k++) begin
				lfsr  = lfsr_step(lfsr);
				delay = delay * 2 + lfsr[0];
			end
			repeat (delay + 1) @(posedge clk);
			#2;
			mem_rdata_i = mem[req_addr[7:0]];
			mem_ack_i   = 1'b1;
			ack_count++;
			@(posedge clk);
			#2;
			mem_ack_i = 1'b0;
		end
	end

	task automatic report_mismatch(input reg [8*24-1:0] name, input string field,
		input logic [31:0] exp, input logic [31:0] act);
		$display("ERROR %0s %0s: expected %h, actual %h", name, field, exp, act);
		test_errors++;
	endtask

	task automatic log_problem(input reg [8*24-1:0] name, input string what);
		$display("%0s: %0s", name, what);
		test_errors++;
	endtask

	// ----------------------------------------------------------------------
	// one bus cycle from the pattern table
	// ----------------------------------------------------------------------
	task automatic run_test(input int idx);
		reg [8*24-1:0] name;
		zaddr_t        addr;
		zdata_t        data;
		zdata_t        exp;
		zdata_t        got;
		logic          is_cfgrd;
		logic          is_cfgwr;
		logic          is_tmo;
		logic          is_mem;
		logic          is_read;
		logic          expect_slave;
		int            stb_before;
		int            ack_before;
		int            wait_n;
		name        = pat_name[idx];
		addr        = pat_addr[idx];
		data        = pat_data[idx];
		exp         = pat_exp[idx];
		is_cfgrd    = (pat_kind[idx] == "cfgrd");
		is_cfgwr    = (pat_kind[idx] == "cfgwr");
		is_tmo      = (pat_kind[idx] == "tmo");
		is_mem      = (pat_kind[idx] == "memrd") || (pat_kind[idx] == "memwr") || is_tmo;
		is_read     = is_cfgrd || is_tmo || (pat_kind[idx] == "memrd");
		// config window is gone once the base is written
		expect_slave = !((is_cfgrd || is_cfgwr) && card_configured);
		test_errors  = 0;
		stb_before   = stb_count;
		ack_before   = ack_count;

		// address phase, AD31:8 plus A7:2
		@(posedge clk);
		#2;
		ad_oe  = 1'b1;
		ad_drv = addr[31:8];
		a_i    = addr[7:2];
		fc_i   = 2'b01;
		read_i = is_read;
		@(posedge clk);
		#2;
		n_fcs_i = 1'b0;
		// data phase
		@(posedge clk);
		#2;
		if (is_read) begin
			ad_oe  = 1'b0;
			n_ds_i = 4'h0;
		end else begin
			ad_drv = {data[31:24], data[15:0]};
			sd_drv = data[23:16];
			n_ds_i = ~pat_be[idx];
		end
		doe_i = 1'b1;
		@(negedge clk);

		if (!expect_slave) begin
			repeat (8) begin
				if (n_slave_o !== 1'b1 || n_dtack_o !== 1'b1)
					log_problem(name, "card answered at FF00 after configuration");
				@(negedge clk);
			end
		end else begin
			if (n_slave_o !== 1'b0)
				log_problem(name, "n_slave_o did not go low");
			while (n_dtack_o !== 1'b0)
				@(negedge clk);
			if (is_mem && (ack_count - ack_before) != 1)
				log_problem(name, "n_dtack_o went low before mem_ack_i");
			if (is_mem && (stb_count - stb_before) != 1)
				report_mismatch(name, "mem_stb_o count", 1, stb_count - stb_before);
			if (is_read) begin
				got = {ad_io[31:24], sd_io, ad_io[23:8]};
				// config reads: nibble on top, ones below
				if (is_cfgrd)
					exp = {exp[3:0], 28'hFFF_FFFF};
				if (got !== exp)
					report_mismatch(name, "read data", exp, got);
			end
			if (is_mem && !is_read) begin
				if (req_we !== 1'b1)
					report_mismatch(name, "mem_we_o", 1, req_we);
				if (req_addr !== addr[25:2])
					report_mismatch(name, "mem_addr_o", addr[25:2], req_addr);
				if (req_wdata !== exp)
					report_mismatch(name, "mem_wdata_o", exp, req_wdata);
				if (req_be !== pat_be[idx])
					report_mismatch(name, "mem_be_o", pat_be[idx], req_be);
			end
			if (is_tmo) begin
				// master keeps /FCS low, slave must let go
				wait_n = 0;
				while (n_dtack_o === 1'b0 && wait_n < `Z3_DTACK_TIMEOUT + 2) begin
					@(negedge clk);
					wait_n++;
				end
				if (n_dtack_o !== 1'b1)
					log_problem(name, "n_dtack_o not released after the timeout");
				repeat (4) begin
					@(negedge clk);
					if (n_dtack_o !== 1'b1)
						log_problem(name, "n_dtack_o low again before n_fcs_i rose");
				end
			end
		end

		// end of cycle
		@(posedge clk);
		#2;
		n_fcs_i = 1'b1;
		doe_i   = 1'b0;
		n_ds_i  = 4'hF;
		ad_oe   = 1'b0;
		read_i  = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (is_cfgwr && expect_slave && addr[8:2] == `Z3_REG_BASE) begin
			card_configured = 1'b1;
			if (n_cfgout_o !== 1'b0)
				report_mismatch(name, "n_cfgout_o", 0, n_cfgout_o);
		end

		if (test_errors == 0) begin
			passed++;
			$display("test %0s: pass", name);
		end else begin
			failed++;
			$display("test %0s: fail, %0d errors", name, test_errors);
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		int            fd;
		int            code;
		int            i;
		reg [8*128-1:0] line;
		reg [8*24-1:0] name_f;
		reg [8*8-1:0]  kind_f;
		zaddr_t        addr_f;
		zdata_t        data_f;
		byte_en_t      be_f;
		zdata_t        exp_f;
		nIORST      = 1'b0;
		n_fcs_i     = 1'b1;
		doe_i       = 1'b0;
		read_i      = 1'b1;
		fc_i        = 2'b01;
		a_i         = '0;
		n_ds_i      = 4'hF;
		n_cfgin_i   = 1'b0;
		n_berr_i    = 1'b1;
		mem_rdata_i = '0;
		mem_ack_i   = 1'b0;
		ad_oe       = 1'b0;
		ad_drv      = '0;
		sd_drv      = '0;
		lfsr        = 32'h646;
		stb_count   = 0;
		ack_count   = 0;
		cycle_limit = 0;
		passed      = 0;
		failed      = 0;
		n_tests     = 0;
		card_configured = 1'b0;
		// fill differs for every word index
		for (i = 0; i < 256; i++)
			mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, 8'hC3};

		fd = $fopen("test/z3_patterns.txt", "r");
		if (fd == 0) begin
			$display("pattern file test/z3_patterns.txt could not be opened");
			$display("Simulation finished: FAIL");
			$finish;
		end else begin
			// comment lines do not yield six fields
			while ($fgets(line, fd) != 0) begin
				code = $sscanf(line, "%s %s %h %h %h %h",
					name_f, kind_f, addr_f, data_f, be_f, exp_f);
				if (code == 6 && n_tests < MAX_TESTS) begin
					pat_name[n_tests] = name_f;
					pat_kind[n_tests] = kind_f;
					pat_addr[n_tests] = addr_f;
					pat_data[n_tests] = data_f;
					pat_be[n_tests]   = be_f;
					pat_exp[n_tests]  = exp_f;
					n_tests++;
				end
			end
			$fclose(fd);
			cycle_limit = 60 * n_tests + 100;

			repeat (2) @(posedge clk);
			#2;
			nIORST = 1'b1;
			@(negedge clk);
			test_errors = 0;
			if (n_dtack_o !== 1'b1 || n_slave_o !== 1'b1 || n_cfgout_o !== 1'b1)
				log_problem("reset", "bus outputs not released after reset");
			if (mem_stb_o !== 1'b0)
				report_mismatch("reset", "mem_stb_o", 0, mem_stb_o);
			if (test_errors == 0) begin
				passed++;
				$display("test reset: pass");
			end else begin
				failed++;
				$display("test reset: fail, %0d errors", test_errors);
			end

			for (i = 0; i < n_tests; i++)
				run_test(i);

			repeat (4) @(posedge clk);
			$display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
				n_tests + 1, passed, failed, u_z3_slave_top.u_checker.assert_fails);
			if (failed == 0 && n_tests > 0 && u_z3_slave_top.u_checker.assert_fails == 0) begin
				$display("Simulation finished: PASS");
			end else begin
				$display("Simulation finished: FAIL");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire
